/* vlog.f */
+incdir+.
adc_attach_pkg.sv
adc_ctrl_if.sv
adc_stat_if.sv
wb_ads5296_attach.sv
adc_delay_seq.sv
adc_clk_monitor.sv
adc_attach_top.sv
tb_adc_attach.sv

/* run_sim.sh */
#!/bin/sh
# compile with verilator and run the testbench, result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_adc_attach -f vlog.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_adc_attach > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

echo "simulation finished without errors"
exit 0

/* tb_adc_attach.sv */
`include "adc_attach_params.svh"

module tb_adc_attach;

  localparam int DLY_W    = `ADC_NUM_DLY;
  localparam int HI_W     = DLY_W - 32;      // bits in the high mask words
  localparam int SLIP_W   = 4 * `ADC_NUM_UNITS;
  localparam int RATIO    = `ADC_FCLK_RATIO;
  localparam int WAIT_MAX = 20;              // cycles allowed for an ack
  localparam int POLL_MAX = 40;              // reads allowed for a counter to settle

  logic                wb_clk_i = 1'b0;
  logic                wb_rst_i;
  logic [31:0]         wb_adr_i;
  logic [31:0]         wb_dat_i;
  logic [3:0]          wb_sel_i;
  logic                wb_we_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic [31:0]         wb_dat_o;
  logic                wb_ack_o;
  logic                wb_err_o;
  logic                mmcm_locked_i;
  logic                mmcm_rst_o;
  logic                mmcm_clksel_o;
  logic                snapshot_trigger_o;
  logic                lclk_i;
  logic [3:0]          fclk_i;
  logic [DLY_W-1:0]    delay_load_o;
  logic [DLY_W-1:0]    delay_rst_o;
  logic [DLY_W-1:0]    delay_en_vtc_o;
  logic [8:0]          delay_val_o;
  logic [SLIP_W-1:0]   bitslip_o;
  logic                iserdes_rst_o;

  logic [4:0]          clk_lvl;          // {fclk3..fclk0, lclk}
  logic [31:0]         rng;
  logic [31:0]         shadow [0:31];    // expected register contents

  assign lclk_i = clk_lvl[0];
  assign fclk_i = clk_lvl[4:1];

  adc_attach_top adc_attach_top_inst (
    .wb_clk_i           (wb_clk_i),
    .wb_rst_i           (wb_rst_i),
    .wb_adr_i           (wb_adr_i),
    .wb_dat_i           (wb_dat_i),
    .wb_sel_i           (wb_sel_i),
    .wb_we_i            (wb_we_i),
    .wb_cyc_i           (wb_cyc_i),
    .wb_stb_i           (wb_stb_i),
    .wb_dat_o           (wb_dat_o),
    .wb_ack_o           (wb_ack_o),
    .wb_err_o           (wb_err_o),
    .mmcm_locked_i      (mmcm_locked_i),
    .mmcm_rst_o         (mmcm_rst_o),
    .mmcm_clksel_o      (mmcm_clksel_o),
    .snapshot_trigger_o (snapshot_trigger_o),
    .lclk_i             (lclk_i),
    .fclk_i             (fclk_i),
    .delay_load_o       (delay_load_o),
    .delay_rst_o        (delay_rst_o),
    .delay_en_vtc_o     (delay_en_vtc_o),
    .delay_val_o        (delay_val_o),
    .bitslip_o          (bitslip_o),
    .iserdes_rst_o      (iserdes_rst_o)
  );

  always #20 wb_clk_i = ~wb_clk_i;   // 40 unit period

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // writable bits per word address
  function automatic logic [31:0] field_mask(input int a);
    case (a)
      0, 2, 4: return 32'hffff_ffff;
      1, 3, 5: return (32'd1 << HI_W) - 32'd1;
      6:       return 32'h0000_01ff;
      8, 16:   return 32'h0000_0001;
      9:       return 32'h0000_0101;   // rst and clksel as locked is read only
      15:      return (32'd1 << SLIP_W) - 32'd1;
      default: return 32'h0;
    endcase
  endfunction

  task stop_run;
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  // returns on the falling edge where ack is seen
  task wb_write(input int a, input logic [31:0] d);
    int waited;
    wb_adr_i = 32'(a) << 2;
    wb_dat_i = d;
    wb_sel_i = 4'hf;
    wb_we_i  = 1'b1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    waited   = 0;
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < WAIT_MAX) begin
      @(negedge wb_clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("no wb ack for write of register %0d", a);
      stop_run();
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task wb_read(input int a, output logic [31:0] d);
    int waited;
    wb_adr_i = 32'(a) << 2;
    wb_sel_i = 4'hf;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    waited   = 0;
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < WAIT_MAX) begin
      @(negedge wb_clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("no wb ack for read of register %0d", a);
      stop_run();
    end
    d = wb_dat_o;   // valid only with ack
    check_eq("wb_err_o", 64'(wb_err_o), 64'd0);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  // poll until the sync and count latency has passed
  task wait_reg_value(input int a, input logic [31:0] exp, input string name);
    logic [31:0] v;
    int          tries;
    tries = 0;
    wb_read(a, v);
    while (v !== exp && tries < POLL_MAX) begin
      wb_read(a, v);
      tries++;
    end
    if (v !== exp) begin
      $display("%s did not settle within %0d reads", name, POLL_MAX);
    end
    check_eq(name, 64'(v), 64'(exp));
  endtask

  // each level held 3 cycles and idx 0 is lclk
  task drive_clk_pulses(input int idx, input int n);
    for (int i = 0; i < n; i++) begin
      clk_lvl[idx] = 1'b1;
      repeat (3) @(negedge wb_clk_i);
      clk_lvl[idx] = 1'b0;
      repeat (3) @(negedge wb_clk_i);
    end
  endtask

  task fclk_period(input int edges);
    drive_clk_pulses(1, 1);      // fclk0 rise opens the period
    drive_clk_pulses(0, edges);
  endtask

  task check_levels;
    check_eq("delay_rst_o", 64'(delay_rst_o), {shadow[3], shadow[2]});
    check_eq("delay_en_vtc_o", 64'(delay_en_vtc_o), {shadow[5], shadow[4]});
    check_eq("delay_val_o", 64'(delay_val_o), 64'(shadow[6]));
    check_eq("iserdes_rst_o", 64'(iserdes_rst_o), 64'(shadow[8][0]));
    check_eq("mmcm_rst_o", 64'(mmcm_rst_o), 64'(shadow[9][0]));
    check_eq("mmcm_clksel_o", 64'(mmcm_clksel_o), 64'(shadow[9][8]));
    check_eq("snapshot_trigger_o", 64'(snapshot_trigger_o), 64'(shadow[16][0]));
  endtask

  task reset_defaults;
    logic [31:0] v;
    check_eq("delay_load_o", 64'(delay_load_o), 64'd0);
    check_eq("bitslip_o", 64'(bitslip_o), 64'd0);
    check_levels();   // shadow is all zero here
    for (int a = 0; a < 17; a++) begin
      wb_read(a, v);
      check_eq($sformatf("reg %0d after reset", a), 64'(v), 64'd0);
    end
    wb_read(17, v);
    check_eq("version", 64'(v), 64'(`ADC_VERSION));
    for (int a = 18; a < 32; a++) begin   // unmapped
      wb_read(a, v);
      check_eq($sformatf("unmapped reg %0d", a), 64'(v), 64'd0);
    end
  endtask

  task reg_readback;
    int          addrs [11];
    logic [31:0] v;
    logic [31:0] exp;
    addrs = '{0, 1, 2, 3, 4, 5, 6, 8, 9, 15, 16};
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 11; i++) begin
        rng = xorshift(rng);
        wb_write(addrs[i], rng);
        shadow[addrs[i]] = rng & field_mask(addrs[i]);
        mmcm_locked_i = rng[20];
        @(negedge wb_clk_i);   // sequencer adds one cycle
        check_levels();
        wb_read(addrs[i], v);
        exp = shadow[addrs[i]];
        if (addrs[i] == 9) exp[16] = mmcm_locked_i;
        check_eq($sformatf("reg %0d readback", addrs[i]), 64'(v), 64'(exp));
      end
    end
    // load and bitslip back to zero for the pulse test
    wb_write(0, 32'h0);
    wb_write(1, 32'h0);
    wb_write(15, 32'h0);
    shadow[0]  = 32'h0;
    shadow[1]  = 32'h0;
    shadow[15] = 32'h0;
  endtask

  // one write and then a few cycles of watching the pulse outputs
  task pulse_expect(input int a, input logic [31:0] d, input logic [63:0] exp);
    logic [63:0] seen;
    logic [63:0] twice;
    logic [63:0] now;
    wb_write(a, d);
    seen  = 64'd0;
    twice = 64'd0;
    for (int c = 0; c < 5; c++) begin
      @(negedge wb_clk_i);
      now   = (a == 15) ? 64'(bitslip_o) : 64'(delay_load_o);
      twice = twice | (seen & now);   // bit high in more than one cycle
      seen  = seen | now;
    end
    check_eq($sformatf("pulses from reg %0d", a), seen, exp);
    check_eq($sformatf("long pulses from reg %0d", a), twice, 64'd0);
  endtask

  task pulse_gen;
    logic [31:0] m;
    logic [31:0] m2;
    logic [31:0] dh;
    logic [31:0] mh;
    logic [31:0] ms;
    rng = xorshift(rng);
    m   = rng;
    rng = xorshift(rng);
    m2  = rng;
    pulse_expect(0, m, {32'd0, m});
    pulse_expect(0, m, 64'd0);            // same mask gives no pulse
    pulse_expect(0, m2, {32'd0, m2 & ~m});  // only new bits pulse
    pulse_expect(0, 32'h0, 64'd0);
    pulse_expect(0, m, {32'd0, m});
    rng = xorshift(rng);
    dh  = rng | 32'h1;                    // at least one high word line set
    mh  = dh & field_mask(1);
    pulse_expect(1, dh, {mh, 32'd0});
    pulse_expect(1, dh, 64'd0);
    pulse_expect(1, 32'h0, 64'd0);
    pulse_expect(1, dh, {mh, 32'd0});
    rng = xorshift(rng);
    ms  = rng & field_mask(15);
    pulse_expect(15, rng, {32'd0, ms});
    pulse_expect(15, rng, 64'd0);
    pulse_expect(15, 32'h0, 64'd0);
    pulse_expect(15, rng, {32'd0, ms});
  endtask

  task edge_counting;
    int n [5];
    wb_write(7, 32'h0);   // clear counters
    for (int idx = 0; idx < 5; idx++) begin
      rng    = xorshift(rng);
      n[idx] = 1 + int'(rng % 32'd6);
      drive_clk_pulses(idx, n[idx]);
    end
    wait_reg_value(10, 32'(n[0]), "lclk_cnt");
    for (int i = 0; i < 4; i++) begin
      wait_reg_value(11 + i, 32'(n[i+1]), $sformatf("fclk_cnt[%0d]", i));
    end
  endtask

  task frame_errors;
    int          bad [4];
    int          lclk_total;
    logic [31:0] v;
    bad = '{RATIO + 1, RATIO - 1, 0, RATIO + 2};
    rng = xorshift(rng);
    wb_write(7, rng);     // data is ignored
    wb_read(7, v);
    check_eq("fclk_err_cnt after clear", 64'(v), 64'd0);
    lclk_total = 0;
    for (int g = 0; g < 3; g++) begin
      fclk_period(RATIO);
      lclk_total += RATIO;
    end
    for (int b = 0; b < 4; b++) begin
      fclk_period(bad[b]);
      lclk_total += bad[b];
    end
    drive_clk_pulses(1, 1);   // closes the last bad period
    wait_reg_value(7, 32'd4, "fclk_err_cnt");
    wait_reg_value(10, 32'(lclk_total), "lclk_cnt");
    wait_reg_value(11, 32'd8, "fclk_cnt[0]");
    wb_write(7, 32'h0);
    wb_read(7, v);
    check_eq("fclk_err_cnt cleared", 64'(v), 64'd0);
    for (int a = 10; a < 15; a++) begin
      wb_read(a, v);
      check_eq($sformatf("count reg %0d cleared", a), 64'(v), 64'd0);
    end
  endtask

  initial begin
    wb_rst_i      = 1'b1;
    wb_adr_i      = 32'h0;
    wb_dat_i      = 32'h0;
    wb_sel_i      = 4'h0;
    wb_we_i       = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    mmcm_locked_i = 1'b0;
    clk_lvl       = 5'b0;
    rng           = 32'h6801_311a;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = 32'h0;
    end
    repeat (2) @(negedge wb_clk_i);   // two rising edges in reset
    wb_rst_i = 1'b0;

    reset_defaults();
    reg_readback();
    pulse_gen();
    edge_counting();
    frame_errors();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* adc_attach_top.sv */
`include "adc_attach_params.svh"

module adc_attach_top (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  logic [31:0]              wb_adr_i,
  input  logic [31:0]              wb_dat_i,
  input  logic [3:0]               wb_sel_i,
  input  logic                     wb_we_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,

  // mmcm and capture control
  input  logic                     mmcm_locked_i,
  output logic                     mmcm_rst_o,
  output logic                     mmcm_clksel_o,
  output logic                     snapshot_trigger_o,

  // sampled clocks
  input  logic                     lclk_i,
  input  logic [3:0]               fclk_i,

  // idelay / iserdes controls
  output logic [`ADC_NUM_DLY-1:0]  delay_load_o,
  output logic [`ADC_NUM_DLY-1:0]  delay_rst_o,
  output logic [`ADC_NUM_DLY-1:0]  delay_en_vtc_o,
  output logic [8:0]               delay_val_o,
  output logic [4*`ADC_NUM_UNITS-1:0] bitslip_o,
  output logic                     iserdes_rst_o
);

  adc_ctrl_if ctrl_if ();
  adc_stat_if stat_if ();

  wb_ads5296_attach wb_ads5296_attach_inst (
    .wb_clk_i           (wb_clk_i),
    .wb_rst_i           (wb_rst_i),
    .wb_adr_i           (wb_adr_i),
    .wb_dat_i           (wb_dat_i),
    .wb_sel_i           (wb_sel_i),
    .wb_we_i            (wb_we_i),
    .wb_cyc_i           (wb_cyc_i),
    .wb_stb_i           (wb_stb_i),
    .wb_dat_o           (wb_dat_o),
    .wb_ack_o           (wb_ack_o),
    .wb_err_o           (wb_err_o),
    .mmcm_locked_i      (mmcm_locked_i),
    .mmcm_rst_o         (mmcm_rst_o),
    .mmcm_clksel_o      (mmcm_clksel_o),
    .snapshot_trigger_o (snapshot_trigger_o),
    .ctrl               (ctrl_if.regs),
    .stat               (stat_if.regs)
  );

  adc_delay_seq adc_delay_seq_inst (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .ctrl           (ctrl_if.seq),
    .delay_load_o   (delay_load_o),
    .delay_rst_o    (delay_rst_o),
    .delay_en_vtc_o (delay_en_vtc_o),
    .delay_val_o    (delay_val_o),
    .bitslip_o      (bitslip_o),
    .iserdes_rst_o  (iserdes_rst_o)
  );

  adc_clk_monitor adc_clk_monitor_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .lclk_i   (lclk_i),
    .fclk_i   (fclk_i),
    .stat     (stat_if.mon)
  );

endmodule

/* adc_clk_monitor.sv */
`include "adc_attach_params.svh"

module adc_clk_monitor import adc_attach_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  logic       lclk_i,
  input  logic [3:0] fclk_i,

  adc_stat_if.mon    stat
);

  localparam int NCLK = 5;   // lclk plus four fclks

  logic [NCLK-1:0] clk_s1;   // {fclk3..fclk0, lclk}
  logic [NCLK-1:0] clk_s2;
  logic [NCLK-1:0] clk_d;    // edge flop
  logic [NCLK-1:0] rise;
  logic            lclk_rise;
  logic            fclk0_rise;

  logic [15:0]     per_cnt;  // lclk edges in the current fclk0 period
  logic            armed;    // a period start has been seen

  assign rise       = clk_s2 & ~clk_d;
  assign lclk_rise  = rise[0];
  assign fclk0_rise = rise[1];

  // two sync flops then the edge flop
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      clk_s1 <= '0;
      clk_s2 <= '0;
      clk_d  <= '0;
    end else begin
      clk_s1 <= {fclk_i, lclk_i};
      clk_s2 <= clk_s1;
      clk_d  <= clk_s2;
    end
  end

  // edge counters
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || stat.cnt_clr) begin
      stat.lclk_cnt <= '0;
      for (int i = 0; i < 4; i++) begin
        stat.fclk_cnt[i] <= '0;
      end
    end else begin
      if (lclk_rise) stat.lclk_cnt <= stat.lclk_cnt + 1'b1;
      for (int i = 0; i < 4; i++) begin
        if (rise[i+1]) stat.fclk_cnt[i] <= stat.fclk_cnt[i] + 1'b1;
      end
    end
  end

  // fclk0 period checker
  // an lclk edge in the same cycle as fclk0 belongs to the new period
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || stat.cnt_clr) begin
      per_cnt           <= '0;
      armed             <= 1'b0;
      stat.fclk_err_cnt <= '0;
    end else if (fclk0_rise) begin
      armed   <= 1'b1;  // first edge only opens a measurement
      per_cnt <= lclk_rise ? 16'd1 : 16'd0;
      if (armed && per_cnt != 16'(`ADC_FCLK_RATIO)) begin
        stat.fclk_err_cnt <= stat.fclk_err_cnt + 1'b1;
      end
    end else if (lclk_rise && per_cnt != '1) begin
      per_cnt <= per_cnt + 1'b1;   // saturates, a stuck fclk still flags
    end
  end

  // errors are only booked on fclk0 edges and both clear together
  err_below_fclk0: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    stat.fclk_err_cnt <= stat.fclk_cnt[0])
    else $error("fclk error count exceeds fclk0 edge count");

endmodule

/* adc_delay_seq.sv */
module adc_delay_seq import adc_attach_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,

  adc_ctrl_if.seq   ctrl,

  output dly_vec_t  delay_load_o,    // one-cycle pulses
  output dly_vec_t  delay_rst_o,
  output dly_vec_t  delay_en_vtc_o,
  output dly_val_t  delay_val_o,
  output slip_vec_t bitslip_o,       // one-cycle pulses
  output logic      iserdes_rst_o
);

  dly_vec_t  load_prev;   // last seen register levels
  slip_vec_t slip_prev;
  dly_vec_t  load_prev_out;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      load_prev      <= '0;
      slip_prev      <= '0;
      delay_load_o   <= '0;
      bitslip_o      <= '0;
      delay_rst_o    <= '0;
      delay_en_vtc_o <= '0;
      delay_val_o    <= '0;
      iserdes_rst_o  <= 1'b0;
    end else begin
      load_prev <= ctrl.dly_load;
      slip_prev <= ctrl.bitslip;
      // 0 -> 1 only, a bit left at 1 stays quiet
      delay_load_o <= ctrl.dly_load & ~load_prev;
      bitslip_o    <= ctrl.bitslip & ~slip_prev;
      // levels, one cycle behind the register
      delay_rst_o    <= ctrl.dly_rst;
      delay_en_vtc_o <= ctrl.dly_en_vtc;
      delay_val_o    <= ctrl.dly_val;
      iserdes_rst_o  <= ctrl.iserdes_rst;
    end
  end

  // previous output, for the pulse width check
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      load_prev_out <= '0;
    end else begin
      load_prev_out <= delay_load_o;
    end
  end

  // idelay must see a single-cycle load per set bit
  load_pulse_width: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (delay_load_o & load_prev_out) == '0)
    else $error("delay load pulse longer than one cycle");

endmodule

/* wb_ads5296_attach.sv */
`include "adc_attach_params.svh"

module wb_ads5296_attach import adc_attach_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,

  input  logic        mmcm_locked_i,
  output logic        mmcm_rst_o,
  output logic        mmcm_clksel_o,
  output logic        snapshot_trigger_o,

  adc_ctrl_if.regs    ctrl,
  adc_stat_if.regs    stat
);

  localparam int DLY_W  = `ADC_NUM_DLY;
  localparam int HI_W   = DLY_W - 32;       // fclk + sync bits in the high word
  localparam int SLIP_W = 4 * `ADC_NUM_UNITS;

  logic        ack_q;
  logic [31:0] rd_data_q;   // captured at acceptance and shown with ack
  logic [31:0] rd_mux;
  logic        accept;
  logic [4:0]  reg_adr;
  logic [31:0] wmask;       // byte enables spread to bits
  logic        cnt_clr_q;

  // control registers
  dly_vec_t    dly_load_q;
  dly_vec_t    dly_rst_q;
  dly_vec_t    dly_en_vtc_q;
  dly_val_t    dly_val_q;
  slip_vec_t   bitslip_q;
  logic        iserdes_rst_q;
  logic        mmcm_rst_q;
  logic        mmcm_clksel_q;
  logic        snapshot_q;

  assign accept  = wb_stb_i && wb_cyc_i && !ack_q;  // no new cycle while ack is up
  assign reg_adr = wb_adr_i[6:2];
  assign wmask   = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};

  // keep unselected bytes of a field
  function automatic logic [31:0] wr_merge(input logic [31:0] cur);
    return (cur & ~wmask) | (wb_dat_i & wmask);
  endfunction

  // read mux with zero-extended fields
  always_comb begin
    rd_mux = 32'b0;
    case (reg_adr)
      `ADC_REG_LOAD_LO:   rd_mux = dly_load_q[31:0];
      `ADC_REG_LOAD_HI:   rd_mux = 32'(dly_load_q[DLY_W-1:32]);
      `ADC_REG_RST_LO:    rd_mux = dly_rst_q[31:0];
      `ADC_REG_RST_HI:    rd_mux = 32'(dly_rst_q[DLY_W-1:32]);
      `ADC_REG_VTC_LO:    rd_mux = dly_en_vtc_q[31:0];
      `ADC_REG_VTC_HI:    rd_mux = 32'(dly_en_vtc_q[DLY_W-1:32]);
      `ADC_REG_DLY_VAL:   rd_mux = 32'(dly_val_q);
      `ADC_REG_ERR_CNT:   rd_mux = stat.fclk_err_cnt;
      `ADC_REG_ISERDES:   rd_mux = {31'b0, iserdes_rst_q};
      // master flag at bit 24 stays low as this attachment is never master
      `ADC_REG_MMCM:      rd_mux = {7'b0, 1'b0, 7'b0, mmcm_locked_i,
                                    7'b0, mmcm_clksel_q, 7'b0, mmcm_rst_q};
      `ADC_REG_LCLK_CNT:  rd_mux = stat.lclk_cnt;
      `ADC_REG_FCLK0_CNT: rd_mux = stat.fclk_cnt[0];
      `ADC_REG_FCLK1_CNT: rd_mux = stat.fclk_cnt[1];
      `ADC_REG_FCLK2_CNT: rd_mux = stat.fclk_cnt[2];
      `ADC_REG_FCLK3_CNT: rd_mux = stat.fclk_cnt[3];
      `ADC_REG_BITSLIP:   rd_mux = 32'(bitslip_q);
      `ADC_REG_SNAPSHOT:  rd_mux = {31'b0, snapshot_q};
      `ADC_REG_VERSION:   rd_mux = `ADC_VERSION;
      default:            rd_mux = 32'b0;   // unmapped
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q         <= 1'b0;
      cnt_clr_q     <= 1'b0;
      dly_load_q    <= '0;
      dly_rst_q     <= '0;
      dly_en_vtc_q  <= '0;
      dly_val_q     <= '0;
      bitslip_q     <= '0;
      iserdes_rst_q <= 1'b0;
      mmcm_rst_q    <= 1'b0;
      mmcm_clksel_q <= 1'b0;
      snapshot_q    <= 1'b0;
    end else begin
      ack_q     <= accept;  // high for the one cycle after acceptance
      cnt_clr_q <= 1'b0;
      if (accept && wb_we_i) begin
        case (reg_adr)
          `ADC_REG_LOAD_LO: dly_load_q[31:0] <= wr_merge(dly_load_q[31:0]);
          `ADC_REG_LOAD_HI:
            dly_load_q[DLY_W-1:32] <= HI_W'(wr_merge(32'(dly_load_q[DLY_W-1:32])));
          `ADC_REG_RST_LO:  dly_rst_q[31:0] <= wr_merge(dly_rst_q[31:0]);
          `ADC_REG_RST_HI:
            dly_rst_q[DLY_W-1:32] <= HI_W'(wr_merge(32'(dly_rst_q[DLY_W-1:32])));
          `ADC_REG_VTC_LO:  dly_en_vtc_q[31:0] <= wr_merge(dly_en_vtc_q[31:0]);
          `ADC_REG_VTC_HI:
            dly_en_vtc_q[DLY_W-1:32] <= HI_W'(wr_merge(32'(dly_en_vtc_q[DLY_W-1:32])));
          `ADC_REG_DLY_VAL: dly_val_q <= 9'(wr_merge(32'(dly_val_q)));
          `ADC_REG_ERR_CNT: cnt_clr_q <= 1'b1;  // data ignored
          `ADC_REG_ISERDES: begin
            if (wb_sel_i[0]) iserdes_rst_q <= wb_dat_i[0];
          end
          `ADC_REG_MMCM: begin
            if (wb_sel_i[0]) mmcm_rst_q <= wb_dat_i[0];
            if (wb_sel_i[1]) mmcm_clksel_q <= wb_dat_i[8];
          end
          `ADC_REG_BITSLIP: bitslip_q <= SLIP_W'(wr_merge(32'(bitslip_q)));
          `ADC_REG_SNAPSHOT: begin
            if (wb_sel_i[0]) snapshot_q <= wb_dat_i[0];
          end
          default: ;  // counters and version are read only
        endcase
      end
    end
  end

  // read data taken when a cycle is accepted
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rd_data_q <= wb_we_i ? 32'b0 : rd_mux;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = ack_q ? rd_data_q : 32'b0;
  assign wb_err_o = 1'b0;   // no error responses

  assign ctrl.dly_load    = dly_load_q;
  assign ctrl.dly_rst     = dly_rst_q;
  assign ctrl.dly_en_vtc  = dly_en_vtc_q;
  assign ctrl.dly_val     = dly_val_q;
  assign ctrl.bitslip     = bitslip_q;
  assign ctrl.iserdes_rst = iserdes_rst_q;
  assign stat.cnt_clr     = cnt_clr_q;

  assign mmcm_rst_o         = mmcm_rst_q;
  assign mmcm_clksel_o      = mmcm_clksel_q;
  assign snapshot_trigger_o = snapshot_q;

  // a held strobe must still see ack drop between transfers
  ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb ack held for two cycles");

  err_never_set: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_cyc_i |-> !wb_err_o)
    else $error("wb err raised");

endmodule

/* adc_stat_if.sv */
// clock monitor <-> register bank
interface adc_stat_if import adc_attach_pkg::*; ();

  cnt_t lclk_cnt;
  cnt_t fclk_cnt [4];   // one per fclk input
  cnt_t fclk_err_cnt;   // bad fclk0 periods
  logic cnt_clr;        // one cycle, from a write to reg 7

  modport mon (
    output lclk_cnt,
    output fclk_cnt,
    output fclk_err_cnt,
    input  cnt_clr
  );

  modport regs (
    input  lclk_cnt,
    input  fclk_cnt,
    input  fclk_err_cnt,
    output cnt_clr
  );

endinterface

/* adc_ctrl_if.sv */
// register bank -> delay sequencer
interface adc_ctrl_if import adc_attach_pkg::*; ();

  dly_vec_t  dly_load;    // level, sequencer makes the pulse
  dly_vec_t  dly_rst;
  dly_vec_t  dly_en_vtc;
  dly_val_t  dly_val;     // shared by all lines
  slip_vec_t bitslip;     // level, sequencer makes the pulse
  logic      iserdes_rst;

  modport regs (
    output dly_load,
    output dly_rst,
    output dly_en_vtc,
    output dly_val,
    output bitslip,
    output iserdes_rst
  );

  modport seq (
    input dly_load,
    input dly_rst,
    input dly_en_vtc,
    input dly_val,
    input bitslip,
    input iserdes_rst
  );

endinterface

/* adc_attach_pkg.sv */
`include "adc_attach_params.svh"

package adc_attach_pkg;

  // one bit per idelay line, lanes first, then fclks, sync on top
  typedef logic [`ADC_NUM_DLY-1:0] dly_vec_t;

  // one bitslip per lane
  typedef logic [4*`ADC_NUM_UNITS-1:0] slip_vec_t;

  // edge and error counters
  typedef logic [31:0] cnt_t;

  // tap value for the idelay load
  typedef logic [8:0] dly_val_t;

endpackage

/* adc_attach_params.svh */
`ifndef ADC_ATTACH_PARAMS_SVH
`define ADC_ATTACH_PARAMS_SVH

// adc chips, 4 lanes x 2 delay lines each
`define ADC_NUM_UNITS   4
`define ADC_NUM_FCLKS   1   // frame clocks that own a delay line
// lanes, frame clocks, plus one for sync_out
`define ADC_NUM_DLY     (8 * `ADC_NUM_UNITS + `ADC_NUM_FCLKS + 1)
`define ADC_VERSION     32'h0001_0300
`define ADC_FCLK_RATIO  4   // lclk rising edges per fclk0 period

// word addresses, wb_adr_i[6:2]
`define ADC_REG_LOAD_LO    5'd0
`define ADC_REG_LOAD_HI    5'd1
`define ADC_REG_RST_LO     5'd2
`define ADC_REG_RST_HI     5'd3
`define ADC_REG_VTC_LO     5'd4
`define ADC_REG_VTC_HI     5'd5
`define ADC_REG_DLY_VAL    5'd6
`define ADC_REG_ERR_CNT    5'd7   // write clears all counters
`define ADC_REG_ISERDES    5'd8
`define ADC_REG_MMCM       5'd9
`define ADC_REG_LCLK_CNT   5'd10
`define ADC_REG_FCLK0_CNT  5'd11
`define ADC_REG_FCLK1_CNT  5'd12
`define ADC_REG_FCLK2_CNT  5'd13
`define ADC_REG_FCLK3_CNT  5'd14
`define ADC_REG_BITSLIP    5'd15
`define ADC_REG_SNAPSHOT   5'd16
`define ADC_REG_VERSION    5'd17

`endif
